/* verilog.f */
source/emesh_pkg.sv
source/node_pkg.sv
source/node_req_if.sv
source/sram_if.sv
source/emesh_if.sv
source/packet_decode.sv
source/node_sram.sv
source/node_ctrl.sv
source/emesh_node.sv
bench/emesh_node_tb.sv

/* bench/emesh_node_tb.sv */
// Directed tests for the memory node; the host model holds each request until emesh_wait_out is low
`timescale 1ns/10ps

module emesh_node_tb;
   import emesh_pkg::*;
   import node_pkg::*;

   // Transactions per test set the run limit
   localparam int N_WRRD   = 8;
   localparam int N_ACK    = 3;
   localparam int N_MISS   = 3;
   localparam int N_BP     = 2;
   localparam int N_RAND   = 40;
   localparam int N_TXN    = N_WRRD + N_ACK + N_MISS + N_BP + N_RAND;
   localparam int MAX_CYCLES = 20*N_TXN + 100;

   logic clk = 1'b0;
   logic rst;
   logic emesh_access_in;
   logic [PW-1:0] emesh_packet_in;
   logic emesh_wait_out;
   logic emesh_access_out;
   logic [PW-1:0] emesh_packet_out;
   logic emesh_wait_in;

   logic [31:0] model [MEM_DEPTH];
   logic model_valid [MEM_DEPTH];
   integer seed = 76387;
   int error_count = 0;
   int check_count = 0;
   int cycle_count = 0;

   emesh_node UUT (
      .clk              (clk),
      .rst              (rst),
      .emesh_access_in  (emesh_access_in),
      .emesh_packet_in  (emesh_packet_in),
      .emesh_wait_out   (emesh_wait_out),
      .emesh_access_out (emesh_access_out),
      .emesh_packet_out (emesh_packet_out),
      .emesh_wait_in    (emesh_wait_in)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout: no end of test after %0d cycles", MAX_CYCLES);
         $display("Simulation failed");
         $finish;
      end
   end

   //##################################################
   // Helpers
   //##################################################
   // Fields from bit 0 up are write, datamode, ctrlmode, dstaddr, data and srcaddr
   function automatic logic [PW-1:0] make_packet(input logic write, input logic [3:0] ctrl,
         input logic [31:0] dst, input logic [31:0] data, input logic [31:0] src);
      return {src, data, dst, ctrl, 3'd2, write};
   endfunction

   function automatic logic in_node(input logic [31:0] addr);
      return addr[31:10] == NODE_BASE[31:10];
   endfunction

   task automatic check_value(input string name, input logic [PW-1:0] expected,
         input logic [PW-1:0] actual);
      check_count++;
      assert (actual === expected) else begin
         error_count++;
         $display("FAIL %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic send_packet(input logic [PW-1:0] pkt);
      @(negedge clk);
      emesh_access_in = 1'b1;
      emesh_packet_in = pkt;
      while (emesh_wait_out) @(negedge clk);
      // Taken at the next rising edge
      @(negedge clk);
      emesh_access_in = 1'b0;
   endtask

   // Hold the response for a number of cycles before taking it
   task automatic receive_packet(input string name, input int hold, output logic [PW-1:0] got);
      emesh_wait_in = (hold != 0);
      while (!emesh_access_out) @(negedge clk);
      got = emesh_packet_out;
      repeat (hold) begin
         @(negedge clk);
         check_value({name, " held access"}, 1, emesh_access_out);
         check_value({name, " held packet"}, got, emesh_packet_out);
         check_value({name, " held wait"}, 1, emesh_wait_out);
      end
      emesh_wait_in = 1'b0;
      @(negedge clk);
      check_value({name, " access after take"}, 0, emesh_access_out);
      check_value({name, " wait after take"}, 0, emesh_wait_out);
   endtask

   task automatic watch_idle(input string name, input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         check_value({name, " no response"}, 0, emesh_access_out);
      end
   endtask

   task automatic write_word(input string name, input logic [31:0] addr,
         input logic [31:0] data, input logic ack, input logic [31:0] src);
      logic [PW-1:0] got;
      send_packet(make_packet(1'b1, {3'b000, ack}, addr, data, src));
      if (in_node(addr) && ack) begin
         receive_packet(name, 0, got);
         check_value(name, make_packet(1'b1, 4'h0, src, data, addr), got);
      end else begin
         check_value({name, " wait"}, 1, emesh_wait_out);
         @(negedge clk);
         check_value({name, " wait one cycle"}, 0, emesh_wait_out);
         watch_idle(name, 4);
      end
      if (in_node(addr)) begin
         model[addr[9:2]] = data;
         model_valid[addr[9:2]] = 1'b1;
      end
   endtask

   task automatic read_check(input string name, input logic [31:0] addr,
         input logic [31:0] src, input int hold);
      logic [PW-1:0] got;
      logic [31:0] exp_data;
      exp_data = in_node(addr) ? model[addr[9:2]] : BAD_DATA;
      send_packet(make_packet(1'b0, 4'h0, addr, 32'h0, src));
      receive_packet(name, hold, got);
      check_value(name, make_packet(1'b1, 4'h0, src, exp_data, addr), got);
   endtask

   //##################################################
   // Tests
   //##################################################
   task automatic reset_state();
      check_value("reset access", 0, emesh_access_out);
      check_value("reset wait", 0, emesh_wait_out);
   endtask

   task automatic write_read_back();
      logic [7:0] idx_list [4] = '{8'h00, 8'h01, 8'h5A, 8'hFF};
      logic [31:0] addr;
      foreach (idx_list[i]) begin
         addr = {NODE_BASE[31:10], idx_list[i], 2'b00};
         write_word("write_read wr", addr, addr ^ 32'h5A5A_0F0F, 1'b0, 32'h1000_0000);
         read_check("write_read rd", addr, 32'h1000_0100 + i, 0);
      end
   endtask

   task automatic write_acks();
      write_word("ack write", NODE_BASE | 32'h80, 32'hCAFE_0080, 1'b1, 32'h3000_0001);
      write_word("plain write", NODE_BASE | 32'h84, 32'hCAFE_0084, 1'b0, 32'h3000_0002);
      read_check("plain readback", NODE_BASE | 32'h84, 32'h3000_0003, 0);
   endtask

   // Write miss aliases index 0x5A of the node
   task automatic address_misses();
      read_check("read miss", 32'h4000_0010, 32'h5000_0001, 0);
      write_word("write miss", 32'h9000_0168, 32'h1234_5678, 1'b1, 32'h5000_0002);
      read_check("miss readback", NODE_BASE | 32'h168, 32'h5000_0003, 0);
   endtask

   task automatic back_pressure();
      int hold;
      logic [PW-1:0] got;
      hold = 3 + ($unsigned($random(seed)) % 6);
      read_check("bp read", NODE_BASE | 32'h4, 32'h6000_0001, hold);
      hold = 3 + ($unsigned($random(seed)) % 6);
      send_packet(make_packet(1'b1, 4'h1, NODE_BASE | 32'h8, 32'h0BAD_F00D, 32'h6000_0002));
      model[2] = 32'h0BAD_F00D;
      model_valid[2] = 1'b1;
      receive_packet("bp ack", hold, got);
      check_value("bp ack", make_packet(1'b1, 4'h0, 32'h6000_0002, 32'h0BAD_F00D,
                  NODE_BASE | 32'h8), got);
   endtask

   task automatic random_traffic();
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [7:0] idx;
      logic ack;
      for (int i = 0; i < N_RAND; i++) begin
         idx   = $random(seed) & 32'h1F;
         addr  = {NODE_BASE[31:10], idx, 2'b00};
         if (($random(seed) & 7) == 0) begin
            addr = addr ^ 32'h4000_0000;
         end
         wdata = $random(seed);
         ack   = $random(seed) & 1;
         // Unwritten words are written first so every read has a known value
         if (($random(seed) & 1) || (in_node(addr) && !model_valid[idx])) begin
            write_word("random write", addr, wdata, ack, 32'h2000_0000 + i);
         end else begin
            read_check("random read", addr, 32'h2000_0000 + i, 0);
         end
      end
   endtask

   initial begin
      rst = 1'b1;
      emesh_access_in = 1'b0;
      emesh_packet_in = '0;
      emesh_wait_in = 1'b0;
      foreach (model_valid[i]) model_valid[i] = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      reset_state();
      write_read_back();
      write_acks();
      address_misses();
      back_pressure();
      random_traffic();
      repeat (4) @(negedge clk);
      $display("Checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* source/emesh_node.sv */
// Memory node top; xmesh is tied off and the host must hold a request while emesh_wait_out is high
`timescale 1ns/10ps

module emesh_node (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     emesh_access_in,
   input  logic [emesh_pkg::PW-1:0] emesh_packet_in,
   output logic                     emesh_wait_out,
   output logic                     emesh_access_out,
   output logic [emesh_pkg::PW-1:0] emesh_packet_out,
   input  logic                     emesh_wait_in
);
   import emesh_pkg::*;

   // Request path
   logic cmesh_req_access;
   logic rmesh_req_access;
   logic [PW-1:0] req_packet;
   logic busy;

   // Response path
   logic cmesh_resp_access;
   logic rmesh_resp_access;
   logic [PW-1:0] resp_packet;
   logic cmesh_resp_wait;
   logic rmesh_resp_wait;

   node_req_if req_bus ();
   sram_if mem_bus ();

   //##################################################
   // Splitter and merger
   //##################################################
   emesh_if u_emesh_if (
      .cmesh_access_in  (cmesh_resp_access),
      .cmesh_packet_in  (resp_packet),
      .cmesh_wait_out   (cmesh_resp_wait),
      .cmesh_access_out (cmesh_req_access),
      .cmesh_packet_out (req_packet),
      .cmesh_wait_in    (busy),
      .rmesh_access_in  (rmesh_resp_access),
      .rmesh_packet_in  (resp_packet),
      .rmesh_wait_out   (rmesh_resp_wait),
      .rmesh_access_out (rmesh_req_access),
      .rmesh_packet_out (),
      .rmesh_wait_in    (busy),
      .xmesh_access_in  (1'b0),
      .xmesh_packet_in  ('0),
      .xmesh_wait_out   (),
      .xmesh_access_out (),
      .xmesh_packet_out (),
      .xmesh_wait_in    (1'b0),
      .emesh_access_in  (emesh_access_in),
      .emesh_packet_in  (emesh_packet_in),
      .emesh_wait_out   (emesh_wait_out),
      .emesh_access_out (emesh_access_out),
      .emesh_packet_out (emesh_packet_out),
      .emesh_wait_in    (emesh_wait_in)
   );

   packet_decode u_decode (
      .cmesh_access (cmesh_req_access),
      .rmesh_access (rmesh_req_access),
      .packet       (req_packet),
      .req          (req_bus.decode)
   );

   //##################################################
   // Controller and memory
   //##################################################
   node_ctrl u_ctrl (
      .clk               (clk),
      .rst               (rst),
      .req               (req_bus.ctrl),
      .busy              (busy),
      .cmesh_resp_access (cmesh_resp_access),
      .rmesh_resp_access (rmesh_resp_access),
      .resp_packet       (resp_packet),
      .cmesh_resp_wait   (cmesh_resp_wait),
      .rmesh_resp_wait   (rmesh_resp_wait),
      .mem               (mem_bus.ctrl)
   );

   node_sram u_sram (
      .clk (clk),
      .mem (mem_bus.mem)
   );

endmodule

/* source/node_ctrl.sv */
// Serves one request at a time; a response is held on its own channel until that channel's wait drops
`timescale 1ns/10ps

module node_ctrl (
   input  logic                     clk,
   input  logic                     rst,
   node_req_if.ctrl                 req,
   output logic                     busy,
   output logic                     cmesh_resp_access,
   output logic                     rmesh_resp_access,
   output logic [emesh_pkg::PW-1:0] resp_packet,
   input  logic                     cmesh_resp_wait,
   input  logic                     rmesh_resp_wait,
   sram_if.ctrl                     mem
);
   import emesh_pkg::*;
   import node_pkg::*;

   node_state_t state;
   logic resp_access_q;

   // Latched request
   node_op_t op_q;
   mesh_channel_t ch_q;
   logic [MEM_AW-1:0] index_q;
   logic [DW-1:0] data_q;
   logic [AW-1:0] dst_q;
   logic [AW-1:0] src_q;

   logic [DW-1:0] resp_data_q;
   logic [DW-1:0] resp_data_next;
   logic chan_wait;

   //##################################################
   // Request FSM
   //##################################################
   always_ff @(posedge clk) begin
      if (rst) begin
         state         <= ST_IDLE;
         resp_access_q <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (req.valid) begin
                  state <= ST_ACCESS;
               end
            end
            ST_ACCESS: begin
               // No response for plain writes or write misses
               if (op_q == OP_WRITE || op_q == OP_WRITE_MISS) begin
                  state <= ST_IDLE;
               end else begin
                  state <= ST_RESP;
               end
            end
            ST_RESP: begin
               // First cycle loads the response, then hold until taken
               if (!resp_access_q) begin
                  resp_access_q <= 1'b1;
               end else if (!chan_wait) begin
                  resp_access_q <= 1'b0;
                  state         <= ST_IDLE;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_IDLE && req.valid) begin
         op_q    <= req.op;
         ch_q    <= req.channel;
         index_q <= req.index;
         data_q  <= req.data;
         dst_q   <= req.dstaddr;
         src_q   <= req.srcaddr;
      end
      if (state == ST_RESP && !resp_access_q) begin
         resp_data_q <= resp_data_next;
      end
   end

   assign busy = (state != ST_IDLE);

   //##################################################
   // Memory access
   //##################################################
   assign mem.en    = (state == ST_ACCESS) && (op_q != OP_WRITE_MISS) &&
                      (op_q != OP_READ_MISS);
   assign mem.we    = (op_q == OP_WRITE) || (op_q == OP_WRITE_ACK);
   assign mem.addr  = index_q;
   assign mem.wdata = data_q;

   //##################################################
   // Response
   //##################################################
   always_comb begin
      case (op_q)
         OP_READ:      resp_data_next = mem.rdata;
         OP_READ_MISS: resp_data_next = BAD_DATA;
         default:      resp_data_next = data_q;
      endcase
   end

   assign chan_wait = (ch_q == CH_CMESH) ? cmesh_resp_wait : rmesh_resp_wait;

   assign cmesh_resp_access = resp_access_q && (ch_q == CH_CMESH);
   assign rmesh_resp_access = resp_access_q && (ch_q == CH_RMESH);

   // Addresses swap so the reply goes back to the requester
   always_comb begin
      resp_packet = '0;
      resp_packet[P_WRITE] = 1'b1;
      resp_packet[P_DATAMODE_MSB:P_DATAMODE_LSB] = DM_WORD;
      resp_packet[P_CTRLMODE_MSB:P_CTRLMODE_LSB] = '0;
      resp_packet[P_DSTADDR_MSB:P_DSTADDR_LSB] = src_q;
      resp_packet[P_DATA_MSB:P_DATA_LSB] = resp_data_q;
      resp_packet[P_SRCADDR_MSB:P_SRCADDR_LSB] = dst_q;
   end

endmodule

/* source/node_sram.sv */
// Contents are undefined after power up and are not cleared by reset
`timescale 1ns/10ps

module node_sram (
   input  logic clk,
   sram_if.mem  mem
);
   import emesh_pkg::*;
   import node_pkg::*;

   logic [DW-1:0] ram [MEM_DEPTH];

   // Write port
   always_ff @(posedge clk) begin
      if (mem.en && mem.we) begin
         ram[mem.addr] <= mem.wdata;
      end
   end

   // Read data is registered and holds until the next read
   always_ff @(posedge clk) begin
      if (mem.en && !mem.we) begin
         mem.rdata <= ram[mem.addr];
      end
   end

endmodule

/* source/packet_decode.sv */
// Datamode is ignored and every access is a word; a hit is decided on dstaddr bits 31..10 only
`timescale 1ns/10ps

module packet_decode (
   input  logic                     cmesh_access,
   input  logic                     rmesh_access,
   input  logic [emesh_pkg::PW-1:0] packet,
   node_req_if.decode               req
);
   import emesh_pkg::*;
   import node_pkg::*;

   logic [AW-1:0] dstaddr;
   logic is_write;
   logic want_ack;
   logic hit;

   //##################################################
   // Field extraction
   //##################################################
   assign dstaddr  = packet[P_DSTADDR_MSB:P_DSTADDR_LSB];
   assign is_write = packet[P_WRITE];
   assign want_ack = packet[P_CTRLMODE_LSB];

   assign req.dstaddr = dstaddr;
   assign req.srcaddr = packet[P_SRCADDR_MSB:P_SRCADDR_LSB];
   assign req.data    = packet[P_DATA_MSB:P_DATA_LSB];
   assign req.index   = dstaddr[TAG_LSB-1:IDX_LSB];

   // Upper address bits select this node
   assign hit = (dstaddr[AW-1:TAG_LSB] == NODE_BASE[AW-1:TAG_LSB]);

   // Only one of the two can be high, since emesh_if splits on the write bit
   assign req.valid   = cmesh_access | rmesh_access;
   assign req.channel = cmesh_access ? CH_CMESH : CH_RMESH;

   //##################################################
   // Classification
   //##################################################
   always_comb begin
      if (is_write) begin
         if (!hit) begin
            req.op = OP_WRITE_MISS;
         end else if (want_ack) begin
            req.op = OP_WRITE_ACK;
         end else begin
            req.op = OP_WRITE;
         end
      end else begin
         req.op = hit ? OP_READ : OP_READ_MISS;
      end
   end

endmodule

/* source/emesh_if.sv */
// Combinational only; xmesh gets no requests, and return merge is fixed priority cmesh, rmesh, xmesh
`timescale 1ns/10ps

module emesh_if (
   // cmesh
   input  logic                     cmesh_access_in,
   input  logic [emesh_pkg::PW-1:0] cmesh_packet_in,
   output logic                     cmesh_wait_out,
   output logic                     cmesh_access_out,
   output logic [emesh_pkg::PW-1:0] cmesh_packet_out,
   input  logic                     cmesh_wait_in,
   // rmesh
   input  logic                     rmesh_access_in,
   input  logic [emesh_pkg::PW-1:0] rmesh_packet_in,
   output logic                     rmesh_wait_out,
   output logic                     rmesh_access_out,
   output logic [emesh_pkg::PW-1:0] rmesh_packet_out,
   input  logic                     rmesh_wait_in,
   // xmesh
   input  logic                     xmesh_access_in,
   input  logic [emesh_pkg::PW-1:0] xmesh_packet_in,
   output logic                     xmesh_wait_out,
   output logic                     xmesh_access_out,
   output logic [emesh_pkg::PW-1:0] xmesh_packet_out,
   input  logic                     xmesh_wait_in,
   // emesh
   input  logic                     emesh_access_in,
   input  logic [emesh_pkg::PW-1:0] emesh_packet_in,
   output logic                     emesh_wait_out,
   output logic                     emesh_access_out,
   output logic [emesh_pkg::PW-1:0] emesh_packet_out,
   input  logic                     emesh_wait_in
);
   import emesh_pkg::*;

   //##################################################
   // Requests from emesh to cmesh and rmesh
   //##################################################

   // Writes go to cmesh, reads to rmesh
   assign cmesh_access_out = emesh_access_in & emesh_packet_in[P_WRITE];
   assign rmesh_access_out = emesh_access_in & ~emesh_packet_in[P_WRITE];
   assign xmesh_access_out = 1'b0;

   // Same packet on every channel
   assign cmesh_packet_out = emesh_packet_in;
   assign rmesh_packet_out = emesh_packet_in;
   assign xmesh_packet_out = emesh_packet_in;

   // Any stalled channel holds the host
   assign emesh_wait_out = cmesh_wait_in | rmesh_wait_in | xmesh_wait_in;

   //##################################################
   // Responses from the channels back to emesh
   //##################################################

   assign emesh_access_out = cmesh_access_in | rmesh_access_in | xmesh_access_in;

   assign emesh_packet_out = cmesh_access_in ? cmesh_packet_in :
                             rmesh_access_in ? rmesh_packet_in :
                                               xmesh_packet_in;

   // Losers wait as well as anyone blocked by the host
   assign cmesh_wait_out = cmesh_access_in & emesh_wait_in;
   assign rmesh_wait_out = rmesh_access_in & (emesh_wait_in | cmesh_access_in);
   assign xmesh_wait_out = xmesh_access_in &
                           (emesh_wait_in | cmesh_access_in | rmesh_access_in);

endmodule

/* source/sram_if.sv */
// Single-port memory port; rdata is valid the cycle after a read enable
`timescale 1ns/10ps

interface sram_if;
   import emesh_pkg::*;
   import node_pkg::*;

   logic en;
   logic we;
   logic [MEM_AW-1:0] addr;
   logic [DW-1:0] wdata;
   logic [DW-1:0] rdata;

   modport ctrl (output en, we, addr, wdata, input rdata);

   modport mem (input en, we, addr, wdata, output rdata);

endinterface

/* source/node_req_if.sv */
// Carries one decoded request; valid is combinational and holds as long as the host holds access
`timescale 1ns/10ps

interface node_req_if;
   import emesh_pkg::*;
   import node_pkg::*;

   logic valid;
   mesh_channel_t channel;
   node_op_t op;
   logic [MEM_AW-1:0] index;
   logic [DW-1:0] data;
   logic [AW-1:0] dstaddr;
   logic [AW-1:0] srcaddr;

   // Decoder side
   modport decode (
      output valid, channel, op, index, data, dstaddr, srcaddr
   );

   // Controller side
   modport ctrl (
      input valid, channel, op, index, data, dstaddr, srcaddr
   );

endinterface

/* source/node_pkg.sv */
// Memory node map assumes a 1 KB window at NODE_BASE, word addressed, 32-bit words only
package node_pkg;

   //##################################################
   // Memory map
   //##################################################
   localparam logic [31:0] NODE_BASE = 32'h8000_0000;
   localparam int MEM_DEPTH = 256;
   localparam int MEM_AW    = 8;
   // Word index sits above the byte offset
   localparam int IDX_LSB   = 2;
   localparam int TAG_LSB   = MEM_AW + IDX_LSB;

   // Read data for addresses outside the node
   localparam logic [31:0] BAD_DATA = 32'hDEAD_BEEF;

   // Request classes
   typedef enum logic [2:0] {
      OP_WRITE,
      OP_WRITE_ACK,
      OP_READ,
      OP_WRITE_MISS,
      OP_READ_MISS
   } node_op_t;

   // Controller states
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ACCESS,
      ST_RESP
   } node_state_t;

endpackage

/* source/emesh_pkg.sv */
// Packet layout for the 104-bit e-mesh format only; multicast and non-word modes are not described
package emesh_pkg;

   // Widths
   localparam int AW = 32;
   localparam int DW = 32;
   localparam int PW = 2*AW+40;

   //##################################################
   // Packet field positions
   //##################################################
   localparam int P_WRITE        = 0;
   localparam int P_DATAMODE_LSB = 1;
   localparam int P_DATAMODE_MSB = 3;
   // Ctrlmode bit 0 requests a write acknowledge
   localparam int P_CTRLMODE_LSB = 4;
   localparam int P_CTRLMODE_MSB = 7;
   localparam int P_DSTADDR_LSB  = 8;
   localparam int P_DSTADDR_MSB  = 39;
   localparam int P_DATA_LSB     = 40;
   localparam int P_DATA_MSB     = 71;
   localparam int P_SRCADDR_LSB  = 72;
   localparam int P_SRCADDR_MSB  = 103;

   // Word access
   localparam logic [2:0] DM_WORD = 3'd2;

   // Channel a request came in on
   typedef enum logic {
      CH_CMESH,
      CH_RMESH
   } mesh_channel_t;

endpackage
